/* bench/dcache_ctrl_sva.sv */
`timescale 1ns/1ps

module dcache_ctrl_sva (
    input logic                clk,
    input logic                rstn,
    input dc_pkg::dc_bus_req_s bus_req,
    input dc_pkg::dc_bus_rsp_s bus_rsp,
    input dc_pkg::dc_we_u      mem_we,
    input logic [1:0]          tag_dv_we
);

    import dc_pkg::*;

    ////////////////////
    // Read address channel
    ////////////////////

    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        bus_req.arvalid && !bus_rsp.arready |=> bus_req.arvalid && $stable(bus_req.araddr))
        else $error("arvalid dropped or araddr changed before arready");

    ////////////////////
    // Write enables
    ////////////////////

    // Only one way is written at a time
    we_one_way: assert property (@(posedge clk) disable iff (!rstn)
        !((|mem_we.way[0]) && (|mem_we.way[1])))
        else $error("mem_we is active in both ways at once");

    tag_with_data: assert property (@(posedge clk) disable iff (!rstn)
        (|tag_dv_we) |-> (|mem_we.word))
        else $error("tag_dv_we is set without any data write enable");

endmodule

bind dcache_ctrl_top dcache_ctrl_sva sva0 (
    .clk       (clk),
    .rstn      (rstn),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .mem_we    (mem_we),
    .tag_dv_we (tag_dv_we)
);

/* bench/dcache_ctrl_tb.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl_tb;

    import dc_pkg::*;

    localparam int K_ST_HIT = 0;
    localparam int K_LD_HIT = 1;
    localparam int K_MISS   = 2;
    localparam int K_UNC_RD = 3;
    localparam int K_UNC_WR = 4;

    typedef struct {
        string       name;
        int          kind;
        logic [2:0]  mt;
        logic [3:0]  ofs;
        logic [1:0]  hit;
        logic        way_sel;
        logic [31:0] exp_we;
    } row_t;

    logic        clk;
    logic        rstn;
    logic        rvalid;
    logic        wvalid;
    logic        way_sel;
    logic        write_finish;
    logic [1:0]  hit;
    dc_req_s     req;
    dc_bus_rsp_s bus_rsp;
    dc_we_u      mem_we;
    logic [1:0]  tag_dv_we;
    dc_bus_req_s bus_req;
    dc_buf_we_s  buf_we;
    dc_lru_s     lru;
    logic        rready;
    logic        wready;
    logic        wfsm_en;
    logic        wfsm_rset;

    row_t   rows[$];
    string  cur_name;
    integer seed;

    dcache_ctrl_top dut0 (
        .clk          (clk),
        .rstn         (rstn),
        .rvalid       (rvalid),
        .wvalid       (wvalid),
        .way_sel      (way_sel),
        .write_finish (write_finish),
        .hit          (hit),
        .req          (req),
        .bus_rsp      (bus_rsp),
        .mem_we       (mem_we),
        .tag_dv_we    (tag_dv_we),
        .bus_req      (bus_req),
        .buf_we       (buf_we),
        .lru          (lru),
        .rready       (rready),
        .wready       (wready),
        .wfsm_en      (wfsm_en),
        .wfsm_rset    (wfsm_rset)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Last line of defense against a stuck run
    initial begin
        #200us;
        abort_run("Simulation watchdog expired before the test finished");
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERROR %s %s: expected %h, actual %h", cur_name, what, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "check failed");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Tag bit of the hit way, only when the store writes any byte
    function automatic logic [1:0] hit_tag(input logic [1:0] h, input logic [31:0] we);
        if (we == 32'h0) begin
            return 2'b00;
        end else begin
            return h[0] ? 2'b01 : 2'b10;
        end
    endfunction

    task automatic add_row(input string name, input int kind, input logic [2:0] mt,
                           input logic [3:0] ofs, input logic [1:0] h, input logic ws,
                           input logic [31:0] exp_we);
        row_t r;
        r.name    = name;
        r.kind    = kind;
        r.mt      = mt;
        r.ofs     = ofs;
        r.hit     = h;
        r.way_sel = ws;
        r.exp_we  = exp_we;
        rows.push_back(r);
    endtask

    ////////////////////
    // Bus and write-back sequences
    ////////////////////

    // Runs from MISS_A until the cycle after the last beat
    task automatic fetch_line(input logic [31:0] addr);
        int delay;
        int waited;
        int beats;
        bit done;
        delay = $random(seed) & 3;
        waited = 0;
        done = 0;
        bus_rsp.arready = (delay == 0);
        while (!done) begin
            @(negedge clk);
            check_eq("arvalid", 1, bus_req.arvalid);
            check_eq("araddr", {addr[31:4], 4'h0}, bus_req.araddr);
            check_eq("mem_we", 0, mem_we.word);
            if (bus_rsp.arready) begin
                done = 1;
            end
            waited++;
            if (waited > 20) begin
                abort_run("Timeout: address handshake never completed");
            end
            next_cycle();
            bus_rsp.arready = (waited == delay);
        end
        bus_rsp.arready = 1'b0;
        beats = 0;
        waited = 0;
        done = 0;
        while (!done) begin
            bus_rsp.rvalid = (($random(seed) & 1) != 0);
            bus_rsp.rlast  = bus_rsp.rvalid && (beats == 3);
            @(negedge clk);
            check_eq("d_rready", 1, bus_req.rready);
            check_eq("mem_we", 0, mem_we.word);
            if (bus_rsp.rvalid) begin
                beats++;
            end
            if (bus_rsp.rlast) begin
                done = 1;
            end
            waited++;
            if (waited > 60) begin
                abort_run("Timeout: last data beat never accepted");
            end
            next_cycle();
        end
        bus_rsp = '0;
    endtask

    // Runs from WAIT_WRITE until the IDLE sample point
    task automatic finish_write();
        int delay;
        int waited;
        bit done;
        delay = $random(seed) & 7;
        waited = 0;
        done = 0;
        while (!done) begin
            write_finish = (waited == delay);
            @(negedge clk);
            check_eq("busy rready", 0, rready);
            check_eq("wait wfsm_en", 0, wfsm_en);
            check_eq("mem_we", 0, mem_we.word);
            if (write_finish) begin
                done = 1;
            end
            waited++;
            if (waited > 20) begin
                abort_run("Timeout: controller never left the write wait");
            end
            next_cycle();
        end
        write_finish = 1'b0;
        @(negedge clk);
        check_eq("idle rready", 1, rready);
        check_eq("idle wfsm_rset", 1, wfsm_rset);
    endtask

    ////////////////////
    // One table row
    ////////////////////

    task automatic run_row(input row_t r);
        logic [31:0] addr;
        cur_name = r.name;
        addr = $random(seed);
        addr[3:0] = r.ofs;
        next_cycle();
        req.address       = addr;
        req.mem_type_pipe = r.mt;
        req.uncache_pipe  = (r.kind == K_UNC_RD) || (r.kind == K_UNC_WR);
        req.wvalid_pipe   = (r.kind == K_ST_HIT) || (r.kind == K_UNC_WR);
        req.rvalid_pipe   = !req.wvalid_pipe;
        rvalid  = req.rvalid_pipe;
        wvalid  = req.wvalid_pipe;
        hit     = 2'b00;
        way_sel = r.way_sel;
        @(negedge clk);
        check_eq("idle wfsm_rset", 1, wfsm_rset);
        next_cycle();
        rvalid = (r.kind == K_LD_HIT);
        wvalid = 1'b0;
        hit    = r.hit;
        @(negedge clk);
        case (r.kind)
            K_ST_HIT: begin
                check_eq("mem_we", r.exp_we, mem_we.word);
                check_eq("tag_dv_we", hit_tag(r.hit, r.exp_we), tag_dv_we);
                check_eq("wready", 1, wready);
                next_cycle();
                hit = 2'b00;
                @(negedge clk);
                check_eq("idle wfsm_rset", 1, wfsm_rset);
            end
            K_LD_HIT: begin
                check_eq("rready", 1, rready);
                check_eq("lru_update", 1, lru.lru_update);
                check_eq("mem_we", r.exp_we, mem_we.word);
                next_cycle();
                rvalid = 1'b0;
                @(negedge clk);
                check_eq("lookup again lru_update", 1, lru.lru_update);
                check_eq("lookup again wfsm_rset", 0, wfsm_rset);
                next_cycle();
                hit = 2'b00;
                @(negedge clk);
                check_eq("idle wfsm_rset", 1, wfsm_rset);
                check_eq("idle lru_update", 0, lru.lru_update);
            end
            K_MISS: begin
                check_eq("mbuf_we", 1, buf_we.mbuf_we);
                check_eq("wbuf_we", 1, buf_we.wbuf_we);
                next_cycle();
                fetch_line(addr);
                @(negedge clk);
                check_eq("refill mem_we", r.exp_we, mem_we.word);
                check_eq("refill tag_dv_we", r.way_sel ? 2'b10 : 2'b01, tag_dv_we);
                check_eq("miss_lru_update", 1, lru.miss_lru_update);
                check_eq("miss_lru_way", r.way_sel, lru.miss_lru_way);
                next_cycle();
                finish_write();
            end
            K_UNC_RD: begin
                check_eq("mem_we", r.exp_we, mem_we.word);
                next_cycle();
                fetch_line(addr);
                finish_write();
            end
            default: begin
                check_eq("wfsm_en", 1, wfsm_en);
                check_eq("mem_we", r.exp_we, mem_we.word);
                next_cycle();
                finish_write();
            end
        endcase
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        seed         = 32'h87b3;
        rstn         = 1'b0;
        rvalid       = 1'b0;
        wvalid       = 1'b0;
        way_sel      = 1'b0;
        write_finish = 1'b0;
        hit          = 2'b00;
        req          = '0;
        bus_rsp      = '0;

        // Offsets in bytes
        // Way 1 sits in the upper half of mem_we
        add_row("sw_w0_o4",  K_ST_HIT, 3'b001, 4'h4, 2'b01, 1'b0, 32'h0000_00f0);
        add_row("sw_w1_o9",  K_ST_HIT, 3'b001, 4'h9, 2'b10, 1'b0, 32'h0f00_0000);
        add_row("sb_w0_o5",  K_ST_HIT, 3'b110, 4'h5, 2'b01, 1'b0, 32'h0000_0020);
        add_row("sb_w1_of",  K_ST_HIT, 3'b110, 4'hf, 2'b10, 1'b0, 32'h8000_0000);
        add_row("sh_w0_o2",  K_ST_HIT, 3'b111, 4'h2, 2'b01, 1'b0, 32'h0000_000c);
        add_row("sh_w1_oe",  K_ST_HIT, 3'b111, 4'he, 2'b10, 1'b0, 32'hc000_0000);
        add_row("sh_odd_o3", K_ST_HIT, 3'b111, 4'h3, 2'b01, 1'b0, 32'h0000_0000);
        add_row("ld_type",   K_ST_HIT, 3'b000, 4'h0, 2'b01, 1'b0, 32'h0000_0000);
        add_row("load_hit",  K_LD_HIT, 3'b000, 4'h8, 2'b10, 1'b0, 32'h0000_0000);
        add_row("miss_w0",   K_MISS,   3'b000, 4'h6, 2'b00, 1'b0, 32'h0000_ffff);
        add_row("miss_w1",   K_MISS,   3'b000, 4'hc, 2'b00, 1'b1, 32'hffff_0000);
        add_row("unc_read",  K_UNC_RD, 3'b000, 4'h4, 2'b00, 1'b0, 32'h0000_0000);
        add_row("unc_write", K_UNC_WR, 3'b001, 4'h0, 2'b00, 1'b0, 32'h0000_0000);

        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        cur_name = "reset";
        check_eq("rready", 1, rready);
        check_eq("wready", 1, wready);
        check_eq("rbuf_we", 1, buf_we.rbuf_we);
        check_eq("data_from_mem_sel", 1, buf_we.data_from_mem_sel);
        check_eq("wfsm_rset", 1, wfsm_rset);
        check_eq("arvalid", 0, bus_req.arvalid);
        check_eq("mem_we", 0, mem_we.word);
        check_eq("tag_dv_we", 0, tag_dv_we);
        check_eq("mbuf_we", 0, buf_we.mbuf_we);
        check_eq("wbuf_we", 0, buf_we.wbuf_we);
        check_eq("wfsm_en", 0, wfsm_en);
        check_eq("lru_update", 0, lru.lru_update);

        foreach (rows[i]) begin
            run_row(rows[i]);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* design/dcache_config.svh */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Address and line geometry
`define DC_ADDR_W      32
`define DC_LINE_BYTES  16
`define DC_OFS_W       4

// Two ways, one write-enable bit per byte of each way
`define DC_WAYS        2
`define DC_WE_W        32

// Memory access type field
`define DC_MT_W        3

// Store type codes
`define DC_MT_ST_W     3'b001
`define DC_MT_ST_B     3'b110
`define DC_MT_ST_H     3'b111

`endif

/* design/dcache_ctrl_fsm.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl_fsm (
    input  logic                clk,
    input  logic                rstn,
    input  logic                rvalid,
    input  logic                wvalid,
    input  logic                way_sel,
    input  logic                write_finish,
    input  logic [1:0]          hit,
    input  dc_pkg::dc_req_s     req,
    input  dc_pkg::dc_we_u      store_we,
    input  dc_pkg::dc_bus_rsp_s bus_rsp,
    output dc_pkg::dc_we_u      mem_we,
    output logic [1:0]          tag_dv_we,
    output dc_pkg::dc_bus_req_s bus_req,
    output dc_pkg::dc_buf_we_s  buf_we,
    output dc_pkg::dc_lru_s     lru,
    output logic                rready,
    output logic                wready,
    output logic                wfsm_en,
    output logic                wfsm_rset
);

    import dc_pkg::*;

    dc_state_e state;
    dc_state_e next_state;
    logic      any_hit;
    logic      new_req;

    assign any_hit = |hit;
    assign new_req = rvalid | wvalid;

    ////////////////////
    // State register
    ////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////
    // Next state and outputs
    ////////////////////

    always_comb begin
        // Defaults shared by most states
        next_state               = state;
        mem_we                   = '0;
        tag_dv_we                = '0;
        bus_req                  = '0;
        buf_we                   = '0;
        buf_we.data_from_mem_sel = 1'b1;
        lru                      = '0;
        rready                   = 1'b0;
        wready                   = 1'b0;
        wfsm_en                  = 1'b0;
        wfsm_rset                = 1'b0;

        case (state)
            IDLE: begin
                if (new_req) begin
                    next_state = LOOKUP;
                end
                buf_we.rbuf_we = 1'b1;
                rready         = 1'b1;
                wready         = 1'b1;
                wfsm_rset      = 1'b1;
            end

            LOOKUP: begin
                if (req.uncache_pipe) begin
                    // Uncached read fetches, uncached write goes out directly
                    if (req.rvalid_pipe) begin
                        next_state = MISS_A;
                    end else begin
                        next_state = WAIT_WRITE;
                        wfsm_en    = 1'b1;
                    end
                end else if (any_hit) begin
                    next_state               = new_req ? LOOKUP : IDLE;
                    buf_we.rbuf_we           = 1'b1;
                    buf_we.data_from_mem_sel = 1'b0;
                    lru.lru_update           = 1'b1;
                    if (req.wvalid_pipe) begin
                        wready = 1'b1;
                        mem_we = store_we;
                        // Tag bit of the way that actually takes bytes
                        tag_dv_we = {|store_we.way[1], |store_we.way[0]};
                    end else begin
                        rready = 1'b1;
                    end
                end else begin
                    next_state     = MISS_A;
                    buf_we.mbuf_we = 1'b1;
                    buf_we.wbuf_we = 1'b1;
                    wfsm_en        = 1'b1;
                end
            end

            MISS_A: begin
                if (bus_rsp.arready) begin
                    next_state = MISS;
                end
                bus_req.arvalid = 1'b1;
                // Line aligned request
                bus_req.araddr  = {req.address[`DC_ADDR_W-1:`DC_OFS_W], {`DC_OFS_W{1'b0}}};
            end

            MISS: begin
                if (bus_rsp.rvalid && bus_rsp.rlast) begin
                    next_state = req.uncache_pipe ? WAIT_WRITE : REFILL;
                end
                bus_req.rready = 1'b1;
            end

            REFILL: begin
                next_state           = WAIT_WRITE;
                mem_we.way[way_sel]  = '1;
                tag_dv_we[way_sel]   = 1'b1;
                lru.miss_lru_update  = 1'b1;
                lru.miss_lru_way     = way_sel;
            end

            WAIT_WRITE: begin
                if (write_finish) begin
                    next_state = IDLE;
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

/* design/dcache_ctrl_top.sv */
`timescale 1ns/1ps

module dcache_ctrl_top (
    input  logic                clk,
    input  logic                rstn,
    input  logic                rvalid,
    input  logic                wvalid,
    input  logic                way_sel,
    input  logic                write_finish,
    input  logic [1:0]          hit,
    input  dc_pkg::dc_req_s     req,
    input  dc_pkg::dc_bus_rsp_s bus_rsp,
    output dc_pkg::dc_we_u      mem_we,
    output logic [1:0]          tag_dv_we,
    output dc_pkg::dc_bus_req_s bus_req,
    output dc_pkg::dc_buf_we_s  buf_we,
    output dc_pkg::dc_lru_s     lru,
    output logic                rready,
    output logic                wready,
    output logic                wfsm_en,
    output logic                wfsm_rset
);

    import dc_pkg::*;

    // Store mask for the lookup stage
    dc_we_u store_we;

    store_mask_gen smg0 (
        .req      (req),
        .hit      (hit),
        .store_we (store_we)
    );

    dcache_ctrl_fsm fsm0 (
        .clk          (clk),
        .rstn         (rstn),
        .rvalid       (rvalid),
        .wvalid       (wvalid),
        .way_sel      (way_sel),
        .write_finish (write_finish),
        .hit          (hit),
        .req          (req),
        .store_we     (store_we),
        .bus_rsp      (bus_rsp),
        .mem_we       (mem_we),
        .tag_dv_we    (tag_dv_we),
        .bus_req      (bus_req),
        .buf_we       (buf_we),
        .lru          (lru),
        .rready       (rready),
        .wready       (wready),
        .wfsm_en      (wfsm_en),
        .wfsm_rset    (wfsm_rset)
    );

endmodule

/* design/dcache_pkg.sv */
`include "dcache_config.svh"

package dc_pkg;

    // Encodings match the existing cache controller
    typedef enum logic [2:0] {
        IDLE       = 3'h0,
        LOOKUP     = 3'h1,
        MISS       = 3'h2,
        REFILL     = 3'h3,
        WAIT_WRITE = 3'h4,
        MISS_A     = 3'h5
    } dc_state_e;

    // Request registered into the lookup stage
    typedef struct packed {
        logic                  wvalid_pipe;
        logic                  rvalid_pipe;
        logic                  uncache_pipe;
        logic [`DC_MT_W-1:0]   mem_type_pipe;
        logic [`DC_ADDR_W-1:0] address;
    } dc_req_s;

    // Read channel toward memory
    typedef struct packed {
        logic                  arvalid;
        logic [`DC_ADDR_W-1:0] araddr;
        logic                  rready;
    } dc_bus_req_s;

    typedef struct packed {
        logic arready;
        logic rvalid;
        logic rlast;
    } dc_bus_rsp_s;

    // Read, miss and write buffer strobes
    typedef struct packed {
        logic rbuf_we;
        logic mbuf_we;
        logic wbuf_we;
        logic data_from_mem_sel;
    } dc_buf_we_s;

    typedef struct packed {
        logic lru_update;
        logic miss_lru_update;
        logic miss_lru_way;
    } dc_lru_s;

    // Flat word for the RAMs, per-way byte fields for the mask logic
    typedef union packed {
        logic [`DC_WE_W-1:0]                      word;
        logic [`DC_WAYS-1:0][`DC_LINE_BYTES-1:0] way;
    } dc_we_u;

endpackage

/* design/store_mask_gen.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module store_mask_gen (
    input  dc_pkg::dc_req_s req,
    input  logic [1:0]      hit,
    output dc_pkg::dc_we_u  store_we
);

    import dc_pkg::*;

    localparam logic [`DC_LINE_BYTES-1:0] BYTE_MASK = 'h1;
    localparam logic [`DC_LINE_BYTES-1:0] HALF_MASK = 'h3;
    localparam logic [`DC_LINE_BYTES-1:0] WORD_MASK = 'hf;

    logic [`DC_OFS_W-1:0]      ofs;
    logic [`DC_LINE_BYTES-1:0] byte_en;
    logic                      way_idx;

    assign ofs = req.address[`DC_OFS_W-1:0];

    // hit[0] selects way 0, anything else falls to way 1
    assign way_idx = ~hit[0];

    ////////////////////
    // Byte enables within one line
    ////////////////////

    always_comb begin
        byte_en = '0;
        case (req.mem_type_pipe)
            `DC_MT_ST_W: begin
                byte_en = WORD_MASK << {ofs[3:2], 2'b00};
            end
            `DC_MT_ST_B: begin
                byte_en = BYTE_MASK << ofs;
            end
            `DC_MT_ST_H: begin
                // Misaligned half writes nothing
                if (!ofs[0]) begin
                    byte_en = HALF_MASK << ofs;
                end
            end
            default: begin
                byte_en = '0;
            end
        endcase
    end

    ////////////////////
    // Place into the target way
    ////////////////////

    always_comb begin
        store_we = '0;
        store_we.way[way_idx] = byte_en;
    end

endmodule

/* vlog.f */
+incdir+design
design/dcache_pkg.sv
design/store_mask_gen.sv
design/dcache_ctrl_fsm.sv
design/dcache_ctrl_top.sv
bench/dcache_ctrl_sva.sv
bench/dcache_ctrl_tb.sv
